// ==== hdl/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

    // Core and memory bus widths
    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;
    localparam int BE_W   = WORD_W / 8;

    // Byte address, physical
    typedef logic [ADDR_W-1:0] addr_t;
    // One data word on either side
    typedef logic [WORD_W-1:0] word_t;
    // Bit n enables byte n
    typedef logic [BE_W-1:0]   be_t;

    // Miss handling states
    typedef enum logic [1:0] {
        CACHE_IDLE,
        CACHE_WRITEBACK,
        CACHE_REFILL
    } cache_state_t;

endpackage

`default_nettype wire

// ==== hdl/cache_tag_array.sv ====
`default_nettype none

module cache_tag_array
    import cache_pkg::*;
#(
    parameter int WAYS_W   = 1,
    parameter int LANES_W  = 4,
    parameter int OFFSET_W = 2,
    localparam int WAYS    = 2 ** WAYS_W,
    localparam int LANES   = 2 ** LANES_W,
    localparam int TAG_W   = ADDR_W - 2 - OFFSET_W - LANES_W
) (
    input  logic                    clk,
    input  logic                    rst_n,

    // Lookup port, result one cycle later
    input  logic                    lookup,
    input  logic [LANES_W-1:0]      lookup_lane,
    output logic [WAYS*TAG_W-1:0]   way_tags,
    output logic [WAYS-1:0]         way_valid,
    output logic [WAYS-1:0]         way_dirty,

    // Update port
    input  logic                    fill,
    input  logic [WAYS_W-1:0]       fill_way,
    input  logic [LANES_W-1:0]      fill_lane,
    input  logic [TAG_W-1:0]        fill_tag,
    input  logic                    mark_dirty,
    input  logic                    clean
);

    // Line state bits in flops, one bit per way and lane
    logic [WAYS-1:0][LANES-1:0] valid;
    logic [WAYS-1:0][LANES-1:0] dirty;
    logic [WAYS-1:0][LANES-1:0] valid_next;
    logic [WAYS-1:0][LANES-1:0] dirty_next;

    // Apply this cycle's updates first
    // so a lookup in the same cycle sees them
    always_comb begin
        valid_next = valid;
        dirty_next = dirty;
        if (fill) begin
            valid_next[fill_way][fill_lane] = 1'b1;
            dirty_next[fill_way][fill_lane] = 1'b0;
        end
        if (mark_dirty) begin
            dirty_next[fill_way][fill_lane] = 1'b1;
        end
        if (clean) begin
            dirty_next[fill_way][fill_lane] = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid     <= '0;
            dirty     <= '0;
            way_valid <= '0;
            way_dirty <= '0;
        end else begin
            valid <= valid_next;
            dirty <= dirty_next;
            if (lookup) begin
                for (int w = 0; w < WAYS; w++) begin
                    way_valid[w] <= valid_next[w][lookup_lane];
                    way_dirty[w] <= dirty_next[w][lookup_lane];
                end
            end
        end
    end

    // Tag RAM per way
    for (genvar w = 0; w < WAYS; w++) begin : g_way
        logic [TAG_W-1:0] tags [LANES];

        always_ff @(posedge clk) begin
            if (fill && fill_way == WAYS_W'(w)) begin
                tags[fill_lane] <= fill_tag;
            end
            if (lookup) begin
                way_tags[w*TAG_W +: TAG_W] <= tags[lookup_lane];
            end
        end
    end

    // Refill end and store hit come from different controller states
    a_fill_vs_dirty : assert property (@(posedge clk) disable iff (!rst_n)
        !(fill && mark_dirty));

endmodule

`default_nettype wire

// ==== hdl/cache_data_array.sv ====
`default_nettype none

module cache_data_array
    import cache_pkg::*;
#(
    parameter int WAYS_W   = 1,
    parameter int LANES_W  = 4,
    parameter int OFFSET_W = 2,
    localparam int WAYS    = 2 ** WAYS_W,
    localparam int DEPTH   = 2 ** (LANES_W + OFFSET_W)
) (
    input  logic                    clk,

    // Read port, same word from every way
    input  logic                    read,
    input  logic [LANES_W-1:0]      read_lane,
    input  logic [OFFSET_W-1:0]     read_offset,
    output logic [WAYS*WORD_W-1:0]  way_data,

    // Byte-masked write port into one way
    input  logic                    write,
    input  logic [WAYS_W-1:0]       write_way,
    input  logic [LANES_W-1:0]      write_lane,
    input  logic [OFFSET_W-1:0]     write_offset,
    input  word_t                   write_data,
    input  be_t                     write_be
);

    logic [LANES_W+OFFSET_W-1:0] read_addr;
    logic [LANES_W+OFFSET_W-1:0] write_addr;

    assign read_addr  = {read_lane, read_offset};
    assign write_addr = {write_lane, write_offset};

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        word_t words [DEPTH];
        word_t read_word;
        logic  write_here;

        assign write_here = write && write_way == WAYS_W'(w);

        // Forward a write to the same word, store hit then next lookup
        always_comb begin
            read_word = words[read_addr];
            if (write_here && write_addr == read_addr) begin
                for (int b = 0; b < BE_W; b++) begin
                    if (write_be[b]) begin
                        read_word[8*b +: 8] = write_data[8*b +: 8];
                    end
                end
            end
        end

        always_ff @(posedge clk) begin
            if (read) begin
                way_data[w*WORD_W +: WORD_W] <= read_word;
            end
            for (int b = 0; b < BE_W; b++) begin
                if (write_here && write_be[b]) begin
                    words[write_addr][8*b +: 8] <= write_data[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/cache_controller.sv ====
`default_nettype none

module cache_controller
    import cache_pkg::*;
#(
    parameter int WAYS_W   = 1,
    parameter int LANES_W  = 4,
    parameter int OFFSET_W = 2,
    localparam int WAYS    = 2 ** WAYS_W,
    localparam int TAG_W   = ADDR_W - 2 - OFFSET_W - LANES_W
) (
    input  logic                    clk,
    input  logic                    rst_n,

    // Core side
    input  addr_t                   c_address,
    input  logic                    c_load,
    input  logic                    c_store,
    input  word_t                   c_store_data,
    input  be_t                     c_store_be,
    output logic                    c_wait,
    output logic                    c_done,
    output word_t                   c_load_data,

    // Tag array
    output logic                    lookup,
    output logic [LANES_W-1:0]      lookup_lane,
    input  logic [WAYS*TAG_W-1:0]   way_tags,
    input  logic [WAYS-1:0]         way_valid,
    input  logic [WAYS-1:0]         way_dirty,
    output logic                    fill,
    output logic [WAYS_W-1:0]       fill_way,
    output logic [LANES_W-1:0]      fill_lane,
    output logic [TAG_W-1:0]        fill_tag,
    output logic                    mark_dirty,
    output logic                    clean,

    // Data array
    output logic                    read,
    output logic [LANES_W-1:0]      read_lane,
    output logic [OFFSET_W-1:0]     read_offset,
    input  logic [WAYS*WORD_W-1:0]  way_data,
    output logic                    write,
    output logic [WAYS_W-1:0]       write_way,
    output logic [LANES_W-1:0]      write_lane,
    output logic [OFFSET_W-1:0]     write_offset,
    output word_t                   write_data,
    output be_t                     write_be,

    // Memory side with one word per transfer
    output addr_t                   m_address,
    output logic                    m_read,
    output logic                    m_write,
    output word_t                   m_writedata,
    input  logic                    m_waitrequest,
    input  word_t                   m_readdata,
    input  logic                    m_readdatavalid
);

    cache_state_t state;

    // Output stage
    logic                   os_active;
    logic                   replay;
    logic [TAG_W-1:0]       os_tag;
    logic [LANES_W-1:0]     os_lane;
    logic [OFFSET_W-1:0]    os_offset;
    logic                   os_store;
    word_t                  os_store_data;
    be_t                    os_be;

    // Miss sequencing
    logic [WAYS_W-1:0]      victim;
    logic [OFFSET_W-1:0]    word_cnt;
    logic                   rd_wait;

    logic                   accept;
    logic [WAYS-1:0]        tag_hit;
    logic                   hit_any;
    logic [WAYS_W-1:0]      hit_way;
    word_t                  hit_word;
    logic                   miss;
    logic                   last_word;
    logic [TAG_W-1:0]       victim_tag;

    assign accept    = (c_load || c_store) && !c_wait;
    assign last_word = word_cnt == {OFFSET_W{1'b1}};

    // Hit compare against every valid way
    always_comb begin
        hit_way  = '0;
        hit_word = way_data[WORD_W-1:0];
        for (int w = 0; w < WAYS; w++) begin
            tag_hit[w] = way_valid[w] && way_tags[w*TAG_W +: TAG_W] == os_tag;
            if (tag_hit[w]) begin
                hit_way  = WAYS_W'(w);
                hit_word = way_data[w*WORD_W +: WORD_W];
            end
        end
    end

    assign hit_any    = |tag_hit;
    assign miss       = os_active && !hit_any;
    assign victim_tag = way_tags[victim*TAG_W +: TAG_W];

    // Core handshake
    assign c_done      = os_active && hit_any;
    assign c_wait      = state != CACHE_IDLE || replay || miss;
    assign c_load_data = hit_word;

    // Lookup on acceptance or again after refill
    assign lookup      = accept || replay;
    assign lookup_lane = replay ? os_lane : c_address[2+OFFSET_W +: LANES_W];

    // Data read also streams the victim line during write-back
    always_comb begin
        read        = lookup;
        read_lane   = lookup_lane;
        read_offset = c_address[2 +: OFFSET_W];
        if (replay) begin
            read_offset = os_offset;
        end else if (miss) begin
            // First victim word for a possible write-back
            read        = 1'b1;
            read_lane   = os_lane;
            read_offset = '0;
        end else if (state == CACHE_WRITEBACK) begin
            read        = !m_waitrequest && !last_word;
            read_lane   = os_lane;
            read_offset = word_cnt + 1'b1;
        end
    end

    // Tag array updates share way and lane
    assign fill       = state == CACHE_REFILL && m_readdatavalid && last_word;
    assign fill_way   = state == CACHE_IDLE ? hit_way : victim;
    assign fill_lane  = os_lane;
    assign fill_tag   = os_tag;
    assign mark_dirty = c_done && os_store;
    assign clean      = state == CACHE_WRITEBACK && !m_waitrequest && last_word;

    // Data write from a store hit or from refill data
    always_comb begin
        write        = mark_dirty;
        write_way    = hit_way;
        write_lane   = os_lane;
        write_offset = os_offset;
        write_data   = os_store_data;
        write_be     = os_be;
        if (state == CACHE_REFILL) begin
            write        = m_readdatavalid;
            write_way    = victim;
            write_offset = word_cnt;
            write_data   = m_readdata;
            write_be     = '1;
        end
    end

    // Memory port
    assign m_write     = state == CACHE_WRITEBACK;
    assign m_read      = state == CACHE_REFILL && !rd_wait;
    assign m_writedata = way_data[victim*WORD_W +: WORD_W];
    assign m_address   = m_write ? {victim_tag, os_lane, word_cnt, 2'b00}
                                 : {os_tag, os_lane, word_cnt, 2'b00};

    // Access payload
    always_ff @(posedge clk) begin
        if (accept) begin
            os_tag        <= c_address[ADDR_W-1 -: TAG_W];
            os_lane       <= c_address[2+OFFSET_W +: LANES_W];
            os_offset     <= c_address[2 +: OFFSET_W];
            os_store      <= c_store;
            os_store_data <= c_store_data;
            os_be         <= c_store_be;
        end
    end

    // Miss FSM
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= CACHE_IDLE;
            os_active <= 1'b0;
            replay    <= 1'b0;
            victim    <= '0;
            word_cnt  <= '0;
            rd_wait   <= 1'b0;
        end else begin
            case (state)
                CACHE_IDLE: begin
                    if (replay) begin
                        replay    <= 1'b0;
                        os_active <= 1'b1;
                    end else if (miss) begin
                        os_active <= 1'b0;
                        if (way_valid[victim] && way_dirty[victim]) begin
                            state <= CACHE_WRITEBACK;
                        end else begin
                            state <= CACHE_REFILL;
                        end
                    end else begin
                        os_active <= accept;
                    end
                end
                CACHE_WRITEBACK: begin
                    // Counter wraps to zero for the refill
                    if (!m_waitrequest) begin
                        word_cnt <= word_cnt + 1'b1;
                        if (last_word) begin
                            state <= CACHE_REFILL;
                        end
                    end
                end
                CACHE_REFILL: begin
                    if (m_read && !m_waitrequest) begin
                        rd_wait <= 1'b1;
                    end
                    if (m_readdatavalid) begin
                        rd_wait  <= 1'b0;
                        word_cnt <= word_cnt + 1'b1;
                        if (last_word) begin
                            state  <= CACHE_IDLE;
                            replay <= 1'b1;
                            victim <= victim + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= CACHE_IDLE;
                end
            endcase
        end
    end

    // A line is filled in one way only
    a_one_hit : assert property (@(posedge clk) disable iff (!rst_n)
        os_active |-> $onehot0(tag_hit));

    a_mem_excl : assert property (@(posedge clk) disable iff (!rst_n)
        !(m_read && m_write));

endmodule

`default_nettype wire

// ==== hdl/cache_top.sv ====
`default_nettype none

module cache_top
    import cache_pkg::*;
#(
    parameter int WAYS_W   = 1,
    parameter int LANES_W  = 4,
    parameter int OFFSET_W = 2,
    localparam int WAYS    = 2 ** WAYS_W,
    localparam int TAG_W   = ADDR_W - 2 - OFFSET_W - LANES_W
) (
    input  logic    clk,
    input  logic    rst_n,

    // Core side
    input  addr_t   c_address,
    input  logic    c_load,
    input  logic    c_store,
    input  word_t   c_store_data,
    input  be_t     c_store_be,
    output logic    c_wait,
    output logic    c_done,
    output word_t   c_load_data,

    // Memory side
    output addr_t   m_address,
    output logic    m_read,
    output logic    m_write,
    output word_t   m_writedata,
    input  logic    m_waitrequest,
    input  word_t   m_readdata,
    input  logic    m_readdatavalid
);

    // Tag array wires
    logic                   lookup;
    logic [LANES_W-1:0]     lookup_lane;
    logic [WAYS*TAG_W-1:0]  way_tags;
    logic [WAYS-1:0]        way_valid;
    logic [WAYS-1:0]        way_dirty;
    logic                   fill;
    logic [WAYS_W-1:0]      fill_way;
    logic [LANES_W-1:0]     fill_lane;
    logic [TAG_W-1:0]       fill_tag;
    logic                   mark_dirty;
    logic                   clean;

    // Data array wires
    logic                   read;
    logic [LANES_W-1:0]     read_lane;
    logic [OFFSET_W-1:0]    read_offset;
    logic [WAYS*WORD_W-1:0] way_data;
    logic                   write;
    logic [WAYS_W-1:0]      write_way;
    logic [LANES_W-1:0]     write_lane;
    logic [OFFSET_W-1:0]    write_offset;
    word_t                  write_data;
    be_t                    write_be;

    cache_tag_array #(
        .WAYS_W     (WAYS_W),
        .LANES_W    (LANES_W),
        .OFFSET_W   (OFFSET_W)
    ) tag_array_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .lookup     (lookup),
        .lookup_lane(lookup_lane),
        .way_tags   (way_tags),
        .way_valid  (way_valid),
        .way_dirty  (way_dirty),
        .fill       (fill),
        .fill_way   (fill_way),
        .fill_lane  (fill_lane),
        .fill_tag   (fill_tag),
        .mark_dirty (mark_dirty),
        .clean      (clean)
    );

    cache_data_array #(
        .WAYS_W      (WAYS_W),
        .LANES_W     (LANES_W),
        .OFFSET_W    (OFFSET_W)
    ) data_array_i (
        .clk         (clk),
        .read        (read),
        .read_lane   (read_lane),
        .read_offset (read_offset),
        .way_data    (way_data),
        .write       (write),
        .write_way   (write_way),
        .write_lane  (write_lane),
        .write_offset(write_offset),
        .write_data  (write_data),
        .write_be    (write_be)
    );

    cache_controller #(
        .WAYS_W         (WAYS_W),
        .LANES_W        (LANES_W),
        .OFFSET_W       (OFFSET_W)
    ) controller_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .c_address      (c_address),
        .c_load         (c_load),
        .c_store        (c_store),
        .c_store_data   (c_store_data),
        .c_store_be     (c_store_be),
        .c_wait         (c_wait),
        .c_done         (c_done),
        .c_load_data    (c_load_data),
        .lookup         (lookup),
        .lookup_lane    (lookup_lane),
        .way_tags       (way_tags),
        .way_valid      (way_valid),
        .way_dirty      (way_dirty),
        .fill           (fill),
        .fill_way       (fill_way),
        .fill_lane      (fill_lane),
        .fill_tag       (fill_tag),
        .mark_dirty     (mark_dirty),
        .clean          (clean),
        .read           (read),
        .read_lane      (read_lane),
        .read_offset    (read_offset),
        .way_data       (way_data),
        .write          (write),
        .write_way      (write_way),
        .write_lane     (write_lane),
        .write_offset   (write_offset),
        .write_data     (write_data),
        .write_be       (write_be),
        .m_address      (m_address),
        .m_read         (m_read),
        .m_write        (m_write),
        .m_writedata    (m_writedata),
        .m_waitrequest  (m_waitrequest),
        .m_readdata     (m_readdata),
        .m_readdatavalid(m_readdatavalid)
    );

endmodule

`default_nettype wire

// ==== tb/cache_mem_model.sv ====
`default_nettype none

module cache_mem_model
    import cache_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  addr_t m_address,
    input  logic  m_read,
    input  logic  m_write,
    input  word_t m_writedata,
    output logic  m_waitrequest,
    output word_t m_readdata,
    output logic  m_readdatavalid
);

    // Unwritten words read as address plus this base
    localparam word_t FILL_BASE = 32'hA500_0000;

    // Only written words are kept
    word_t mem [addr_t];
    // Current request already took its stall cycle
    logic  stalled;

    function automatic word_t word_at(addr_t addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return addr + FILL_BASE;
    endfunction

    // One stall cycle at the start of every transfer
    assign m_waitrequest = (m_read || m_write) && !stalled;

    always @(posedge clk) begin
        if (!rst_n) begin
            stalled         <= 1'b0;
            m_readdatavalid <= 1'b0;
            m_readdata      <= '0;
        end else begin
            stalled         <= (m_read || m_write) && !stalled;
            // Read data one cycle after acceptance
            m_readdatavalid <= m_read && !m_waitrequest;
            if (m_read && !m_waitrequest) begin
                m_readdata <= word_at(m_address);
            end
            if (m_write && !m_waitrequest) begin
                mem[m_address] = m_writedata;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/cache_tb.sv ====
`default_nettype none

module cache_tb
    import cache_pkg::*;
();

    localparam int    CLK_PERIOD      = 20;
    localparam int    DRIVE_DLY       = 2;
    localparam int    RESET_CYCLES    = 2;
    localparam int    CYCLES_PER_LINE = 200;
    localparam string STIM_FILE       = "tb/cache_stim.txt";

    logic  clk;
    logic  rst_n;

    // Core side
    addr_t c_address;
    logic  c_load;
    logic  c_store;
    word_t c_store_data;
    be_t   c_store_be;
    logic  c_wait;
    logic  c_done;
    word_t c_load_data;

    // Memory side
    addr_t m_address;
    logic  m_read;
    logic  m_write;
    word_t m_writedata;
    logic  m_waitrequest;
    word_t m_readdata;
    logic  m_readdatavalid;

    // Accesses from the stimulus file
    // Op bit 1 means store and bit 0 means hit expected
    logic [3:0] ops     [$];
    addr_t      addrs   [$];
    word_t      datas   [$];
    be_t        masks   [$];
    word_t      expects [$];

    int error_count;
    int check_count;
    int cycle_count = 0;
    int cycle_limit;

    cache_top dut_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .c_address      (c_address),
        .c_load         (c_load),
        .c_store        (c_store),
        .c_store_data   (c_store_data),
        .c_store_be     (c_store_be),
        .c_wait         (c_wait),
        .c_done         (c_done),
        .c_load_data    (c_load_data),
        .m_address      (m_address),
        .m_read         (m_read),
        .m_write        (m_write),
        .m_writedata    (m_writedata),
        .m_waitrequest  (m_waitrequest),
        .m_readdata     (m_readdata),
        .m_readdatavalid(m_readdatavalid)
    );

    cache_mem_model mem_model_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .m_address      (m_address),
        .m_read         (m_read),
        .m_write        (m_write),
        .m_writedata    (m_writedata),
        .m_waitrequest  (m_waitrequest),
        .m_readdata     (m_readdata),
        .m_readdatavalid(m_readdatavalid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    // Comment and blank lines give no fields and are skipped
    task automatic load_stimulus(input int fd);
        string      line;
        int         fields;
        int         line_no;
        logic [3:0] op;
        addr_t      addr;
        word_t      data;
        be_t        be;
        word_t      expected;
        line_no = 0;
        while ($fgets(line, fd) != 0) begin
            line_no++;
            fields = $sscanf(line, "%h %h %h %h %h", op, addr, data, be, expected);
            if (fields == 5) begin
                ops.push_back(op);
                addrs.push_back(addr);
                datas.push_back(data);
                masks.push_back(be);
                expects.push_back(expected);
            end else if (fields > 0) begin
                error_count++;
                $display("Stimulus line %0d is malformed: %s", line_no, line);
            end
        end
    endtask

    // One access from request to c_done
    task automatic run_access(input int idx);
        string name;
        logic  is_store;
        logic  want_hit;
        is_store = ops[idx][1];
        want_hit = ops[idx][0];
        name = $sformatf("access %0d %s %h", idx, is_store ? "store" : "load", addrs[idx]);
        @(posedge clk);
        #DRIVE_DLY;
        c_address    = addrs[idx];
        c_load       = !is_store;
        c_store      = is_store;
        c_store_data = datas[idx];
        c_store_be   = masks[idx];
        while (c_wait) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
        // Accepted at this edge
        @(posedge clk);
        #DRIVE_DLY;
        c_load       = 1'b0;
        c_store      = 1'b0;
        // Core payload is free to change once accepted
        c_address    = ~addrs[idx];
        c_store_data = '0;
        c_store_be   = '0;
        if (want_hit) begin
            check_flag({name, " c_done one cycle after accept"}, 1'b1, c_done);
        end else begin
            check_flag({name, " c_wait on miss"}, 1'b1, c_wait);
            check_flag({name, " c_done on miss"}, 1'b0, c_done);
        end
        while (!c_done) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
        check_flag({name, " c_wait at done"}, 1'b0, c_wait);
        if (!is_store) begin
            check_word({name, " load data"}, expects[idx], c_load_data);
        end
    endtask

    // Run limit scales with the number of accesses
    always @(posedge clk) begin : watchdog
        cache_state_t stuck_state;
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            stuck_state = dut_i.controller_i.state;
            $display("Timeout: no result after %0d cycles, controller state %s",
                     cycle_count, stuck_state.name());
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin : main
        int fd;
        c_address    = '0;
        c_load       = 1'b0;
        c_store      = 1'b0;
        c_store_data = '0;
        c_store_be   = '0;
        rst_n        = 1'b0;
        error_count  = 0;
        check_count  = 0;
        cycle_limit  = 0;

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            error_count++;
            $display("Could not open stimulus file %s", STIM_FILE);
        end else begin
            load_stimulus(fd);
            $fclose(fd);
            if (ops.size() == 0) begin
                error_count++;
                $display("Stimulus file %s holds no accesses", STIM_FILE);
            end
        end
        cycle_limit = CYCLES_PER_LINE * ops.size();

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;

        // Idle outputs straight after reset
        check_flag("reset c_wait", 1'b0, c_wait);
        check_flag("reset c_done", 1'b0, c_done);
        check_flag("reset m_read", 1'b0, m_read);
        check_flag("reset m_write", 1'b0, m_write);

        for (int i = 0; i < ops.size(); i++) begin
            run_access(i);
        end

        @(posedge clk);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
hdl/cache_pkg.sv
hdl/cache_tag_array.sv
hdl/cache_data_array.sv
hdl/cache_controller.sv
hdl/cache_top.sv
tb/cache_mem_model.sv
tb/cache_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = cache_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = TEST RESULT: FAIL
PASS_MSG  = TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "No result line in $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb/cache_stim.txt ====
// op: bit 1 store, bit 0 hit expected (0 load miss, 1 load hit, 2 store miss, 3 store hit)
// columns, all hex: op address store_data byte_mask expected_load_data
// Cold miss on lane 1, then hits in the same line
0 00000010 00000000 0 a5000010
1 00000010 00000000 0 a5000010
1 00000014 00000000 0 a5000014
// Masked store hit on bytes 0 and 2
3 00000014 11223344 5 00000000
1 00000014 00000000 0 a5220044
// Two more lines in lane 1 push the dirty line out
0 00000110 00000000 0 a5000110
0 0000021c 00000000 0 a500021c
// Evicted line comes back from memory with the stored bytes
0 00000014 00000000 0 a5220044
1 00000010 00000000 0 a5000010
1 00000018 00000000 0 a5000018
// Store miss on lane 2, refill then write
2 00000320 deadbeef f 00000000
1 00000320 00000000 0 deadbeef
3 00000324 77665544 8 00000000
1 00000324 00000000 0 77000324
// Evict the dirty lane 2 line and read it back
0 00000420 00000000 0 a5000420
0 00000520 00000000 0 a5000520
0 00000324 00000000 0 77000324
1 00000320 00000000 0 deadbeef
1 0000052c 00000000 0 a500052c
// Top of the address space, fill value wraps
0 ffffff3c 00000000 0 a4ffff3c
1 ffffff3c 00000000 0 a4ffff3c
1 0000021c 00000000 0 a500021c
